// File: all.f
+incdir+.
mvu_pkg.sv
dpe_req_if.sv
dpe.sv
mvu_accum.sv
mvu_regs.sv
mvu_sequencer.sv
mvu_top.sv
mvu_assertions.sv
tb_mvu.sv

// File: dpe.sv
`timescale 1ns/1ns
`include "mvu_settings.svh"

module dpe #(
    parameter type tag_t = logic
) (
    input  logic                  clk,
    input  logic                  rst,
    dpe_req_if.snk                i_req,
    output logic                  o_valid,
    output logic [`MVU_OPREC-1:0] o_result,
    output tag_t                  o_tag
);

    localparam int OPREC  = `MVU_OPREC;
    localparam int LEVELS = $clog2(`MVU_LANES);
    // Input register and multiply, then one register per tree level
    localparam int LAT    = 2 + LEVELS;

    logic [`MVU_DATAW-1:0]        r_dataa;
    logic [`MVU_DATAW-1:0]        r_datab;
    logic signed [`MVU_MPREC-1:0] r_prod [`MVU_LANES];
    logic [LAT-1:0]               r_valid;
    tag_t                         r_tag [LAT];

    always_ff @(posedge clk) begin
        r_dataa <= i_req.dataa;
        r_datab <= i_req.datab;
    end

    // Signed product per lane
    always_ff @(posedge clk) begin
        for (int n = 0; n < `MVU_LANES; n++) begin
            r_prod[n] <= $signed(r_dataa[n*`MVU_IPREC +: `MVU_IPREC]) *
                         $signed(r_datab[n*`MVU_IPREC +: `MVU_IPREC]);
        end
    end

    // Pairwise adder tree where each level halves the node count
    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int NODES = `MVU_LANES >> (l + 1);
        logic signed [OPREC-1:0] r_node [NODES];

        if (l == 0) begin : g_leaf
            always_ff @(posedge clk) begin
                for (int n = 0; n < NODES; n++) begin
                    r_node[n] <= OPREC'(r_prod[2*n]) + OPREC'(r_prod[2*n+1]);
                end
            end
        end else begin : g_inner
            always_ff @(posedge clk) begin
                for (int n = 0; n < NODES; n++) begin
                    r_node[n] <= g_level[l-1].r_node[2*n] + g_level[l-1].r_node[2*n+1];
                end
            end
        end
    end

    // Valid follows the data through every stage
    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= '0;
        end else begin
            r_valid <= {r_valid[LAT-2:0], i_req.valid};
        end
    end

    always_ff @(posedge clk) begin
        r_tag[0] <= tag_t'(i_req.tag);
        for (int k = 1; k < LAT; k++) begin
            r_tag[k] <= r_tag[k-1];
        end
    end

    assign o_valid  = r_valid[LAT-1];
    assign o_result = g_level[LEVELS-1].r_node[0];
    assign o_tag    = r_tag[LAT-1];

endmodule

// File: dpe_req_if.sv
`timescale 1ns/1ns
`include "mvu_settings.svh"

// Operand stream with no ready since the engine never stalls
interface dpe_req_if;
    logic                  valid;
    logic [`MVU_DATAW-1:0] dataa;
    logic [`MVU_DATAW-1:0] datab;
    mvu_pkg::mvu_tag_t     tag;

    modport src (
        output valid, dataa, datab, tag
    );

    modport snk (
        input valid, dataa, datab, tag
    );
endinterface

// File: mvu_accum.sv
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_accum (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_valid,
    input  logic [`MVU_OPREC-1:0] i_result,
    input  mvu_pkg::mvu_tag_t     i_tag,
    output logic                  o_wr,
    output mvu_pkg::mvu_row_t     o_row,
    output logic [`MVU_OPREC-1:0] o_sum,
    output logic                  o_done
);

    localparam mvu_pkg::mvu_row_t LAST_ROW = mvu_pkg::mvu_row_t'(`MVU_ROWS - 1);

    logic [`MVU_OPREC-1:0] r_acc;
    logic [`MVU_OPREC-1:0] row_sum;
    logic                  row_end;

    // Sum of the row so far including the incoming word
    assign row_sum = r_acc + i_result;
    assign row_end = i_valid && i_tag.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_acc  <= '0;
            o_wr   <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_wr   <= row_end;
            o_done <= row_end && (i_tag.row == LAST_ROW);
            if (i_valid) begin
                // Restart for the next row after its last word
                r_acc <= i_tag.last ? '0 : row_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_end) begin
            o_row <= i_tag.row;
            o_sum <= row_sum;
        end
    end

endmodule

// File: mvu_assertions.sv
`timescale 1ns/1ns

module mvu_assertions (
    input logic clk,
    input logic rst,
    input logic i_pready,
    input logic i_in_valid,
    input logic i_out_valid,
    input logic i_start,
    input logic i_busy
);

    localparam int DPE_LAT = 4;

    // One bit of engine input valid history per pipeline stage
    logic [DPE_LAT-1:0] r_valid_hist;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid_hist <= '0;
        end else begin
            r_valid_hist <= {r_valid_hist[DPE_LAT-2:0], i_in_valid};
        end
    end

    a_pready: assert property (@(posedge clk) disable iff (rst) i_pready)
        else $error("APB pready was low");

    a_dpe_latency: assert property (@(posedge clk) disable iff (rst)
        i_out_valid == r_valid_hist[DPE_LAT-1])
        else $error("Engine output valid does not follow input valid by 4 cycles");

    a_start_idle: assert property (@(posedge clk) disable iff (rst) !(i_start && i_busy))
        else $error("Start pulse seen while the sequencer is busy");

endmodule

// Engine input valid is the sequencer busy flag
bind mvu_top mvu_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .i_pready    (o_pready),
    .i_in_valid  (busy),
    .i_out_valid (dpe_valid),
    .i_start     (start),
    .i_busy      (busy)
);

// File: mvu_golden.txt
# Per case three lines of hex words: 16 weight words (row r word k at r*4+k, lane 0 in
# the low byte), then 4 vector words, then the 4 expected signed 32-bit row results
# case 0: constant rows against an all-ones vector
01010101 01010101 01010101 01010101 02020202 02020202 02020202 02020202 03030303 03030303 03030303 03030303 04040404 04040404 04040404 04040404
01010101 01010101 01010101 01010101
00000010 00000020 00000030 00000040
# case 1: column index vector, negative and positive rows
ffffffff ffffffff ffffffff ffffffff 01010101 01010101 01010101 01010101 02020202 02020202 02020202 02020202 80808080 80808080 80808080 80808080
03020100 07060504 0b0a0908 0f0e0d0c
ffffff88 00000078 000000f0 ffffc400
# case 2: extreme operands, started twice
80808080 80808080 80808080 80808080 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 00000000 00000000 00000000 00000000 ffffffff ffffffff ffffffff ffffffff
80808080 80808080 80808080 80808080
00040000 fffc0800 00000000 00000800
# case 3: mixed signs per lane
01010101 01010101 01010101 01010101 0a0b0c0d 0a0b0c0d 0a0b0c0d 0a0b0c0d 7f000000 00800000 0000f600 000000c8 81818181 81818181 81818181 81818181
04fd02ff 04fd02ff 04fd02ff 04fd02ff
00000008 00000048 000003a0 fffffc08

// File: mvu_pkg.sv
`include "mvu_settings.svh"

package mvu_pkg;

    // Row index within the matrix
    typedef logic [$clog2(`MVU_ROWS)-1:0] mvu_row_t;

    // Sideband that travels with each operand word
    typedef struct packed {
        mvu_row_t row;
        // High on the final word of a row
        logic     last;
    } mvu_tag_t;

    // STATUS register layout
    typedef struct packed {
        logic done;
        logic busy;
    } mvu_status_t;

endpackage

// File: mvu_regs.sv
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    i_psel,
    input  logic                                    i_penable,
    input  logic                                    i_pwrite,
    input  logic [`MVU_ADDRW-1:0]                   i_paddr,
    input  logic [`MVU_DATAW-1:0]                   i_pwdata,
    output logic [`MVU_DATAW-1:0]                   o_prdata,
    output logic                                    o_pready,
    output logic                                    o_pslverr,
    input  logic                                    i_busy,
    output logic                                    o_start,
    input  logic [$clog2(`MVU_ROWS*`MVU_WORDS)-1:0] i_wgt_idx,
    output logic [`MVU_DATAW-1:0]                   o_wgt,
    input  logic [$clog2(`MVU_WORDS)-1:0]           i_vec_idx,
    output logic [`MVU_DATAW-1:0]                   o_vec,
    input  logic                                    i_res_wr,
    input  mvu_pkg::mvu_row_t                       i_res_row,
    input  logic [`MVU_OPREC-1:0]                   i_res_sum,
    input  logic                                    i_done
);

    localparam int DATAW = `MVU_DATAW;
    localparam int NWGT  = `MVU_ROWS * `MVU_WORDS;
    localparam int WIDXW = $clog2(NWGT);
    localparam int VIDXW = $clog2(`MVU_WORDS);
    localparam int RIDXW = $clog2(`MVU_ROWS);

    logic [`MVU_DATAW-1:0] wgt_mem [NWGT];
    logic [`MVU_DATAW-1:0] vec_mem [`MVU_WORDS];
    logic [`MVU_OPREC-1:0] res_reg [`MVU_ROWS];
    logic                  r_done;

    logic                  access;
    logic                  wr;
    logic                  aligned;
    logic                  hit_ctrl;
    logic                  hit_status;
    logic                  hit_wgt;
    logic                  hit_vec;
    logic                  hit_res;
    logic                  mapped;
    logic                  start_req;
    logic [WIDXW-1:0]      a_wgt;
    logic [VIDXW-1:0]      a_vec;
    logic [RIDXW-1:0]      a_res;
    mvu_pkg::mvu_status_t  status;

    assign access  = i_psel && i_penable;
    assign wr      = access && i_pwrite;
    assign aligned = (i_paddr[1:0] == 2'b00);

    // Only word aligned offsets decode
    assign hit_ctrl   = aligned && (i_paddr == `MVU_A_CTRL);
    assign hit_status = aligned && (i_paddr == `MVU_A_STATUS);
    assign hit_wgt    = aligned && (i_paddr >= `MVU_A_WGT) &&
                        (i_paddr < `MVU_A_WGT + 4 * NWGT);
    assign hit_vec    = aligned && (i_paddr >= `MVU_A_VEC) &&
                        (i_paddr < `MVU_A_VEC + 4 * `MVU_WORDS);
    assign hit_res    = aligned && (i_paddr >= `MVU_A_RES) &&
                        (i_paddr < `MVU_A_RES + 4 * `MVU_ROWS);
    assign mapped     = hit_ctrl || hit_status || hit_wgt || hit_vec || hit_res;

    assign a_wgt = WIDXW'((i_paddr - `MVU_A_WGT) >> 2);
    assign a_vec = VIDXW'((i_paddr - `MVU_A_VEC) >> 2);
    assign a_res = RIDXW'((i_paddr - `MVU_A_RES) >> 2);

    // Results are read only over APB
    assign o_pslverr = access && (!mapped || (i_pwrite && hit_res));
    assign o_pready  = 1'b1;

    // A second start is dropped while a run is pending or in progress
    assign start_req = wr && hit_ctrl && i_pwdata[0] && !i_busy && !o_start;

    assign status = '{done: r_done, busy: i_busy};

    always_comb begin
        o_prdata = '0;
        if (hit_status) begin
            o_prdata = DATAW'(status);
        end else if (hit_wgt) begin
            o_prdata = wgt_mem[a_wgt];
        end else if (hit_vec) begin
            o_prdata = vec_mem[a_vec];
        end else if (hit_res) begin
            o_prdata = DATAW'(res_reg[a_res]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_start <= 1'b0;
            r_done  <= 1'b0;
            for (int i = 0; i < NWGT; i++) begin
                wgt_mem[i] <= '0;
            end
            for (int i = 0; i < `MVU_WORDS; i++) begin
                vec_mem[i] <= '0;
            end
            for (int i = 0; i < `MVU_ROWS; i++) begin
                res_reg[i] <= '0;
            end
        end else begin
            o_start <= start_req;
            if (start_req) begin
                r_done <= 1'b0;
            end else if (i_done) begin
                r_done <= 1'b1;
            end
            if (wr && hit_wgt) begin
                wgt_mem[a_wgt] <= i_pwdata;
            end
            if (wr && hit_vec) begin
                vec_mem[a_vec] <= i_pwdata;
            end
            if (i_res_wr) begin
                res_reg[i_res_row] <= i_res_sum;
            end
        end
    end

    // Combinational read ports for the sequencer
    assign o_wgt = wgt_mem[i_wgt_idx];
    assign o_vec = vec_mem[i_vec_idx];

endmodule

// File: mvu_sequencer.sv
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_sequencer (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    i_start,
    output logic                                    o_busy,
    output logic [$clog2(`MVU_ROWS*`MVU_WORDS)-1:0] o_wgt_idx,
    input  logic [`MVU_DATAW-1:0]                   i_wgt,
    output logic [$clog2(`MVU_WORDS)-1:0]           o_vec_idx,
    input  logic [`MVU_DATAW-1:0]                   i_vec,
    dpe_req_if.src                                  o_req
);

    localparam int WIDXW = $clog2(`MVU_ROWS * `MVU_WORDS);
    localparam int VIDXW = $clog2(`MVU_WORDS);
    localparam mvu_pkg::mvu_row_t LAST_ROW  = mvu_pkg::mvu_row_t'(`MVU_ROWS - 1);
    localparam logic [VIDXW-1:0]  LAST_WORD = VIDXW'(`MVU_WORDS - 1);

    mvu_pkg::mvu_row_t r_row;
    logic [VIDXW-1:0]  r_word;
    logic              last_word;

    assign last_word = (r_word == LAST_WORD);

    // One word per cycle, row-major over the weight matrix
    always_ff @(posedge clk) begin
        if (rst) begin
            o_busy <= 1'b0;
            r_row  <= '0;
            r_word <= '0;
        end else if (i_start && !o_busy) begin
            o_busy <= 1'b1;
            r_row  <= '0;
            r_word <= '0;
        end else if (o_busy) begin
            r_word <= last_word ? '0 : r_word + 1'b1;
            if (last_word) begin
                if (r_row == LAST_ROW) begin
                    o_busy <= 1'b0;
                    r_row  <= '0;
                end else begin
                    r_row <= r_row + 1'b1;
                end
            end
        end
    end

    assign o_wgt_idx = WIDXW'(r_row * `MVU_WORDS + r_word);
    assign o_vec_idx = r_word;

    assign o_req.valid = o_busy;
    assign o_req.dataa = i_wgt;
    assign o_req.datab = i_vec;
    assign o_req.tag   = '{row: r_row, last: last_word};

endmodule

// File: mvu_settings.svh
`ifndef MVU_SETTINGS_SVH
`define MVU_SETTINGS_SVH

// Datapath precisions
`define MVU_LANES 4
`define MVU_IPREC 8
`define MVU_MPREC 16
`define MVU_OPREC 32
`define MVU_DATAW 32

// Matrix shape with 16 columns spread over 4 lanes
`define MVU_ROWS  4
`define MVU_WORDS 4

// APB byte offsets
`define MVU_ADDRW    12
`define MVU_A_CTRL   12'h000
`define MVU_A_STATUS 12'h004
`define MVU_A_WGT    12'h040
`define MVU_A_VEC    12'h080
`define MVU_A_RES    12'h0C0

`endif

// File: mvu_top.sv
`timescale 1ns/1ns
`include "mvu_settings.svh"

module mvu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [`MVU_ADDRW-1:0] i_paddr,
    input  logic [`MVU_DATAW-1:0] i_pwdata,
    output logic [`MVU_DATAW-1:0] o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr
);

    logic                                    busy;
    logic                                    start;
    logic [$clog2(`MVU_ROWS*`MVU_WORDS)-1:0] wgt_idx;
    logic [`MVU_DATAW-1:0]                   wgt;
    logic [$clog2(`MVU_WORDS)-1:0]           vec_idx;
    logic [`MVU_DATAW-1:0]                   vec;
    logic                                    dpe_valid;
    logic [`MVU_OPREC-1:0]                   dpe_result;
    mvu_pkg::mvu_tag_t                       dpe_tag;
    logic                                    res_wr;
    mvu_pkg::mvu_row_t                       res_row;
    logic [`MVU_OPREC-1:0]                   res_sum;
    logic                                    done;

    dpe_req_if req_if ();

    mvu_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_busy    (busy),
        .o_start   (start),
        .i_wgt_idx (wgt_idx),
        .o_wgt     (wgt),
        .i_vec_idx (vec_idx),
        .o_vec     (vec),
        .i_res_wr  (res_wr),
        .i_res_row (res_row),
        .i_res_sum (res_sum),
        .i_done    (done)
    );

    mvu_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .i_start   (start),
        .o_busy    (busy),
        .o_wgt_idx (wgt_idx),
        .i_wgt     (wgt),
        .o_vec_idx (vec_idx),
        .i_vec     (vec),
        .o_req     (req_if)
    );

    dpe #(
        .tag_t (mvu_pkg::mvu_tag_t)
    ) u_dpe (
        .clk      (clk),
        .rst      (rst),
        .i_req    (req_if),
        .o_valid  (dpe_valid),
        .o_result (dpe_result),
        .o_tag    (dpe_tag)
    );

    mvu_accum u_accum (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (dpe_valid),
        .i_result (dpe_result),
        .i_tag    (dpe_tag),
        .o_wr     (res_wr),
        .o_row    (res_row),
        .o_sum    (res_sum),
        .o_done   (done)
    );

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_mvu -o sim_mvu

out=$(./obj_dir/sim_mvu)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi

// File: tb_mvu.sv
`timescale 1ns/1ns
`include "mvu_settings.svh"

module tb_mvu;

    localparam int NCASES            = 4;
    localparam int NWGT              = `MVU_ROWS * `MVU_WORDS;
    localparam int TIMEOUT_CYCLES    = NCASES * 200 + 1000;
    localparam int DRIVE_DLY         = 1;
    localparam int DOUBLE_START_CASE = 2;
    localparam logic [`MVU_ADDRW-1:0] UNMAPPED = 12'h100;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`MVU_ADDRW-1:0] paddr;
    logic [`MVU_DATAW-1:0] pwdata;
    logic [`MVU_DATAW-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    int          n_checks    = 0;
    int          n_errors    = 0;
    int          done_pulses = 0;
    logic [31:0] wgt [NWGT];
    logic [31:0] vec [`MVU_WORDS];
    logic [31:0] exp_res [`MVU_ROWS];

    mvu_top u_mvu_top (
        .clk       (clk),
        .rst       (rst),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Count of accumulator completion pulses
    always @(posedge clk) begin
        if (u_mvu_top.done) begin
            done_pulses <= done_pulses + 1;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic apb_write(input logic [`MVU_ADDRW-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        check($sformatf("write pready at %h", addr), 32'h1, 32'(pready));
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`MVU_ADDRW-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        // Mid cycle of the access phase
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check($sformatf("read pready at %h", addr), 32'h1, 32'(pready));
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Next line that is neither a comment nor empty
    task automatic read_data_line(input int fd, output string line, output bit ok);
        int code;
        code = $fgets(line, fd);
        while (code != 0 && (line.getc(0) == "#" || line.getc(0) == "\n")) begin
            code = $fgets(line, fd);
        end
        ok = (code != 0);
    endtask

    task automatic read_case(input int fd, output bit ok);
        string line;
        bit    got;
        int    n;
        read_data_line(fd, line, got);
        n = got ? $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          wgt[0], wgt[1], wgt[2], wgt[3], wgt[4], wgt[5], wgt[6],
                          wgt[7], wgt[8], wgt[9], wgt[10], wgt[11], wgt[12],
                          wgt[13], wgt[14], wgt[15]) : 0;
        ok = (n == NWGT);
        read_data_line(fd, line, got);
        n = got ? $sscanf(line, "%h %h %h %h", vec[0], vec[1], vec[2], vec[3]) : 0;
        ok = ok && (n == `MVU_WORDS);
        read_data_line(fd, line, got);
        n = got ? $sscanf(line, "%h %h %h %h",
                          exp_res[0], exp_res[1], exp_res[2], exp_res[3]) : 0;
        ok = ok && (n == `MVU_ROWS);
    endtask

    task automatic load_case(input int c);
        logic [31:0] data;
        logic        err;
        for (int i = 0; i < NWGT; i++) begin
            apb_write(`MVU_A_WGT + 12'(4 * i), wgt[i], err);
            check($sformatf("case%0d wgt%0d write err", c, i), 32'h0, 32'(err));
        end
        for (int i = 0; i < `MVU_WORDS; i++) begin
            apb_write(`MVU_A_VEC + 12'(4 * i), vec[i], err);
            check($sformatf("case%0d vec%0d write err", c, i), 32'h0, 32'(err));
        end
        for (int i = 0; i < NWGT; i++) begin
            apb_read(`MVU_A_WGT + 12'(4 * i), data, err);
            check($sformatf("case%0d wgt%0d readback", c, i), wgt[i], data);
        end
        for (int i = 0; i < `MVU_WORDS; i++) begin
            apb_read(`MVU_A_VEC + 12'(4 * i), data, err);
            check($sformatf("case%0d vec%0d readback", c, i), vec[i], data);
        end
    endtask

    task automatic run_case(input int c);
        logic [31:0] data;
        logic        err;
        int          pulses_before;
        pulses_before = done_pulses;
        apb_write(`MVU_A_CTRL, 32'h1, err);
        check($sformatf("case%0d start err", c), 32'h0, 32'(err));
        if (c == DOUBLE_START_CASE) begin
            apb_write(`MVU_A_CTRL, 32'h1, err);
            check($sformatf("case%0d second start err", c), 32'h0, 32'(err));
        end
        // Busy set and done cleared by the new start
        apb_read(`MVU_A_STATUS, data, err);
        check($sformatf("case%0d status after start", c), 32'h1, data);
        do begin
            apb_read(`MVU_A_STATUS, data, err);
        end while (data[1] !== 1'b1);
        for (int r = 0; r < `MVU_ROWS; r++) begin
            apb_read(`MVU_A_RES + 12'(4 * r), data, err);
            check($sformatf("case%0d result row%0d", c, r), exp_res[r], data);
        end
        // Long enough for a stray second run to show up
        repeat (40) @(posedge clk);
        check($sformatf("case%0d done pulses", c), 32'h1, 32'(done_pulses - pulses_before));
        apb_read(`MVU_A_STATUS, data, err);
        check($sformatf("case%0d status at end", c), 32'h2, data);
    endtask

    task automatic error_response();
        logic [31:0] data;
        logic        err;
        apb_read(UNMAPPED, data, err);
        check("unmapped read err", 32'h1, 32'(err));
        check("unmapped read data", 32'h0, data);
        apb_write(`MVU_A_RES + 12'h4, 32'hdeadbeef, err);
        check("result write err", 32'h1, 32'(err));
        apb_read(`MVU_A_RES + 12'h4, data, err);
        check("result after write", exp_res[1], data);
    endtask

    initial begin
        int fd;
        bit ok;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        fd = $fopen("mvu_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open mvu_golden.txt for reading");
            n_errors++;
        end else begin
            for (int c = 0; c < NCASES; c++) begin
                read_case(fd, ok);
                if (!ok) begin
                    $display("Golden file ended early or is malformed at case %0d", c);
                    n_errors++;
                    break;
                end
                load_case(c);
                run_case(c);
            end
            $fclose(fd);
            error_response();
        end
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
